// File: build.f
src/aes_pkg.sv
src/aes_gf_inverse.sv
src/aes_key_expand.sv
src/aes_round.sv
src/aes_core.sv
src/aes_bus_wrapper.sv
sim/tb_aes.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the AES testbench with Verilator; the log decides the result.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_aes -f build.f -o tb_aes_sim

./obj_dir/tb_aes_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification passed" sim.log
then
	echo "simulation result: PASS"
else
	echo "simulation result: FAIL"
	exit 1
fi

// File: sim/tb_aes.sv
// Directed testbench for the AES-128 bus wrapper.
// Covers FIPS-197 vectors, random round trips, key change, busy drop and reset state.
// Compiled from build.f and run by run_sim.sh under Verilator.

`timescale 1ns/1ps

module tb_aes;

	// limit about three times the 1200 cycles the tests take
	localparam int TIMEOUT_CYCLES = 4000;
	// bound on any one wait for key expansion or a result
	localparam int WAIT_LIMIT     = 40;

	localparam aes_pkg::key_t   FIPS_KEY    = 128'h000102030405060708090a0b0c0d0e0f;
	localparam aes_pkg::block_t FIPS_PLAIN  = 128'h00112233445566778899aabbccddeeff;
	localparam aes_pkg::block_t FIPS_CIPHER = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
	localparam aes_pkg::key_t   APPX_KEY    = 128'h2b7e151628aed2a6abf7158809cf4f3c;
	localparam aes_pkg::block_t APPX_PLAIN  = 128'h3243f6a8885a308d313198a2e0370734;
	localparam aes_pkg::block_t APPX_CIPHER = 128'h3925841d02dc09fbdc118597196a0b32;

	logic               clk;
	logic               reset;
	logic               i_enable;
	logic               i_enc_dec;
	aes_pkg::word_t     i_data;
	aes_pkg::data_sel_t i_data_sel;
	logic               i_data_valid;
	aes_pkg::read_sel_t o_data_sel;
	logic               o_key_ready;
	logic               o_ready;
	aes_pkg::word_t     o_data;
	logic               o_data_valid;

	int     error_count = 0;
	int     check_count = 0;
	int     cycle_count = 0;
	integer seed;

	aes_bus_wrapper dut (
		.clk          (clk),
		.reset        (reset),
		.i_enable     (i_enable),
		.i_enc_dec    (i_enc_dec),
		.i_data       (i_data),
		.i_data_sel   (i_data_sel),
		.i_data_valid (i_data_valid),
		.o_data_sel   (o_data_sel),
		.o_key_ready  (o_key_ready),
		.o_ready      (o_ready),
		.o_data       (o_data),
		.o_data_valid (o_data_valid)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// run limit
	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Verification failed");
			$finish;
		end
	end

	// ----------------------------------------------------------
	// compare tasks
	// ----------------------------------------------------------
	task automatic check_block(input string name, input aes_pkg::block_t exp,
		input aes_pkg::block_t act);
		check_count++;
		if (act !== exp)
		begin
			error_count++;
			$display("error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		check_count++;
		if (act !== exp)
		begin
			error_count++;
			$display("error %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	// ----------------------------------------------------------
	// bus access
	// ----------------------------------------------------------
	// these tasks start and end on a falling edge
	task automatic apply_reset();
		reset = 1'b1;
		repeat (16) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
	endtask

	// one word is captured on the next rising edge
	task automatic write_word(input aes_pkg::data_sel_t sel, input aes_pkg::word_t data);
		i_data_valid = 1'b1;
		i_data_sel   = sel;
		i_data       = data;
		@(negedge clk);
		i_data_valid = 1'b0;
	endtask

	task automatic load_key(input aes_pkg::key_t key);
		int waited;
		for (int i = 0; i < 4; i++)
			write_word(aes_pkg::data_sel_t'(i), key[32*i +: 32]);
		// start pulse on this edge and ready drops on the next
		@(negedge clk);
		check_bit("key_ready_low", 1'b0, o_key_ready);
		waited = 0;
		while (!o_key_ready && waited < WAIT_LIMIT)
		begin
			@(negedge clk);
			waited++;
		end
		if (!o_key_ready)
		begin
			error_count++;
			$display("key expansion did not finish within %0d cycles", WAIT_LIMIT);
		end
	endtask

	// select b goes last and starts the block
	task automatic write_block(input aes_pkg::block_t blk);
		for (int i = 0; i < 4; i++)
			write_word(aes_pkg::data_sel_t'(aes_pkg::SEL_DATA_FIRST + i), blk[32*i +: 32]);
	endtask

	task automatic wait_result();
		int waited;
		waited = 0;
		while (!o_data_valid && waited < WAIT_LIMIT)
		begin
			@(negedge clk);
			waited++;
		end
		if (!o_data_valid)
		begin
			error_count++;
			$display("no result pulse within %0d cycles", WAIT_LIMIT);
		end
	endtask

	// registered read mux puts each word out one edge after its select
	task automatic read_block(output aes_pkg::block_t res);
		for (int i = 0; i < 4; i++)
		begin
			o_data_sel = aes_pkg::read_sel_t'(i);
			@(negedge clk);
			res[32*i +: 32] = o_data;
		end
	endtask

	task automatic run_block(input aes_pkg::block_t blk, input logic dec,
		output aes_pkg::block_t res);
		i_enc_dec = dec;
		write_block(blk);
		wait_result();
		read_block(res);
	endtask

	// ----------------------------------------------------------
	// directed tests
	// ----------------------------------------------------------
	task automatic reset_state();
		apply_reset();
		check_bit("reset_ready", 1'b1, o_ready);
		check_bit("reset_key_ready", 1'b0, o_key_ready);
		check_bit("reset_data_valid", 1'b0, o_data_valid);
	endtask

	task automatic encrypt_fips();
		aes_pkg::block_t res;
		load_key(FIPS_KEY);
		run_block(FIPS_PLAIN, 1'b0, res);
		check_block("fips_encrypt", FIPS_CIPHER, res);
	endtask

	// key from the encrypt test stays loaded
	task automatic decrypt_fips();
		aes_pkg::block_t res;
		run_block(FIPS_CIPHER, 1'b1, res);
		check_block("fips_decrypt", FIPS_PLAIN, res);
	endtask

	// inverse cipher must undo the cipher under the same key
	task automatic round_trip();
		aes_pkg::key_t   key;
		aes_pkg::block_t plain;
		aes_pkg::block_t cipher;
		aes_pkg::block_t back;
		for (int n = 0; n < 20; n++)
		begin
			key   = {$random(seed), $random(seed), $random(seed), $random(seed)};
			plain = {$random(seed), $random(seed), $random(seed), $random(seed)};
			load_key(key);
			run_block(plain, 1'b0, cipher);
			run_block(cipher, 1'b1, back);
			check_block($sformatf("round_trip_%0d", n), plain, back);
		end
	endtask

	task automatic key_change();
		aes_pkg::block_t res;
		load_key(APPX_KEY);
		check_bit("key_ready_high", 1'b1, o_key_ready);
		run_block(APPX_PLAIN, 1'b0, res);
		check_block("key_change", APPX_CIPHER, res);
	endtask

	// second block lands while the core is busy and must vanish
	task automatic busy_drop();
		aes_pkg::block_t res;
		int pulses;
		i_enc_dec = 1'b0;
		write_block(APPX_PLAIN);
		@(negedge clk);
		check_bit("busy_ready_low", 1'b0, o_ready);
		write_block(FIPS_PLAIN);
		pulses = 0;
		for (int n = 0; n < WAIT_LIMIT; n++)
		begin
			if (o_data_valid)
				pulses++;
			@(negedge clk);
		end
		check_count++;
		if (pulses != 1)
		begin
			error_count++;
			$display("error busy_drop_pulses: expected 1, actual %0d", pulses);
		end
		read_block(res);
		check_block("busy_drop", APPX_CIPHER, res);
	endtask

	// ----------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------
	initial
	begin
		seed         = 32'hf3b9_0542;
		reset        = 1'b1;
		i_enable     = 1'b1;
		i_enc_dec    = 1'b0;
		i_data       = '0;
		i_data_sel   = '0;
		i_data_valid = 1'b0;
		o_data_sel   = '0;
		reset_state();
		encrypt_fips();
		decrypt_fips();
		round_trip();
		key_change();
		busy_drop();
		// reset again after traffic
		reset_state();
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// File: src/aes_bus_wrapper.sv
// Top level: AES-128 engine behind a 32-bit word-select bus.
// Selects 0-3 write the key (3 starts expansion), 8-b the block (b starts a run).
// o_data_sel picks the result word, registered. i_enc_dec high decrypts.

`timescale 1ns/1ps

module aes_bus_wrapper (
	input  logic                clk,
	input  logic                reset,
	input  logic                i_enable,
	input  logic                i_enc_dec,
	input  aes_pkg::word_t      i_data,
	input  aes_pkg::data_sel_t  i_data_sel,
	input  logic                i_data_valid,
	input  aes_pkg::read_sel_t  o_data_sel,
	output logic                o_key_ready,
	output logic                o_ready,
	output aes_pkg::word_t      o_data,
	output logic                o_data_valid
);

	// assembled key and block, word 0 in bits 31:0
	aes_pkg::key_t   key_reg;
	aes_pkg::block_t data_reg;
	logic            key_start;
	logic            blk_valid;
	aes_pkg::round_t round_idx;
	aes_pkg::key_t   round_key;
	aes_pkg::block_t core_data;

	// ---------------------------------------------------------
	// bus writes
	// ---------------------------------------------------------
	// codes 4-7 and c-f fall through unused
	always_ff @(posedge clk)
	begin
		if (i_data_valid)
		begin
			if (i_data_sel <= aes_pkg::SEL_KEY_LAST)
				key_reg[32*i_data_sel[1:0] +: 32] <= i_data;
			else if ((i_data_sel >= aes_pkg::SEL_DATA_FIRST)
				&& (i_data_sel <= aes_pkg::SEL_DATA_LAST))
				data_reg[32*i_data_sel[1:0] +: 32] <= i_data;
		end
	end

	// one-cycle start pulses after the last word of each
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			key_start <= 1'b0;
			blk_valid <= 1'b0;
		end
		else
		begin
			key_start <= i_data_valid && (i_data_sel == aes_pkg::SEL_KEY_LAST);
			blk_valid <= i_data_valid && (i_data_sel == aes_pkg::SEL_DATA_LAST);
		end
	end

	// ---------------------------------------------------------
	// key schedule and round engine
	// ---------------------------------------------------------
	aes_key_expand u_key_expand (
		.clk         (clk),
		.reset       (reset),
		.i_start     (key_start),
		.i_key       (key_reg),
		.i_round_idx (round_idx),
		.o_round_key (round_key),
		.o_key_ready (o_key_ready)
	);

	aes_core u_core (
		.clk          (clk),
		.reset        (reset),
		.i_enable     (i_enable),
		.i_enc_dec    (i_enc_dec),
		.i_data_valid (blk_valid),
		.i_data       (data_reg),
		.i_key_ready  (o_key_ready),
		.i_round_key  (round_key),
		.o_round_idx  (round_idx),
		.o_ready      (o_ready),
		.o_data       (core_data),
		.o_data_valid (o_data_valid)
	);

	// read mux, one cycle behind o_data_sel
	always_ff @(posedge clk)
	begin
		o_data <= core_data[32*o_data_sel +: 32];
	end

endmodule

// File: src/aes_core.sv
// Iterative AES-128 datapath control, one round per clock.
// Accepts a block when idle with a full key set; the result comes 11 cycles later.
// i_enc_dec high selects decryption, low encryption.

`timescale 1ns/1ps

module aes_core (
	input  logic             clk,
	input  logic             reset,
	input  logic             i_enable,
	input  logic             i_enc_dec,
	input  logic             i_data_valid,
	input  aes_pkg::block_t  i_data,
	input  logic             i_key_ready,
	input  aes_pkg::key_t    i_round_key,
	output aes_pkg::round_t  o_round_idx,
	output logic             o_ready,
	output aes_pkg::block_t  o_data,
	output logic             o_data_valid
);

	aes_pkg::core_state_t fsm;
	aes_pkg::round_t      round_cnt;
	// direction of the block in flight
	logic                 decrypt;
	aes_pkg::block_t      state_q;
	aes_pkg::block_t      round_out;
	logic                 last_round;
	logic                 accept;
	logic                 step;

	// done lasts one cycle and may already take the next block
	assign o_ready      = (fsm != aes_pkg::ST_ROUND);
	assign o_data_valid = (fsm == aes_pkg::ST_DONE);
	assign accept       = o_ready && i_data_valid && i_key_ready;
	assign step         = (fsm == aes_pkg::ST_ROUND) && i_enable;

	// encryption counts 1 to 10, decryption 9 down to 0
	assign last_round = decrypt ? (round_cnt == '0)
		: (round_cnt == aes_pkg::round_t'(aes_pkg::NUM_ROUNDS));

	// ---------------------------------------------------------
	// round key index
	// ---------------------------------------------------------
	// outside the rounds, point at the whitening key for the next block
	always_comb
	begin
		if (fsm == aes_pkg::ST_ROUND)
			o_round_idx = round_cnt;
		else if (i_enc_dec)
			o_round_idx = aes_pkg::round_t'(aes_pkg::NUM_ROUNDS);
		else
			o_round_idx = '0;
	end

	aes_round u_round (
		.i_state     (state_q),
		.i_round_key (i_round_key),
		.i_decrypt   (decrypt),
		.i_last      (last_round),
		.o_state     (round_out)
	);

	// ---------------------------------------------------------
	// control FSM
	// ---------------------------------------------------------
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			fsm       <= aes_pkg::ST_IDLE;
			round_cnt <= '0;
			decrypt   <= 1'b0;
		end
		else
		begin
			case (fsm)
				aes_pkg::ST_IDLE,
				aes_pkg::ST_DONE:
				begin
					if (accept)
					begin
						decrypt   <= i_enc_dec;
						round_cnt <= i_enc_dec ? aes_pkg::round_t'(aes_pkg::NUM_ROUNDS - 1)
							: aes_pkg::round_t'(1);
						fsm       <= aes_pkg::ST_ROUND;
					end
					else
						fsm <= aes_pkg::ST_IDLE;
				end
				aes_pkg::ST_ROUND:
				begin
					// i_enable low holds everything in place
					if (i_enable)
					begin
						if (last_round)
							fsm <= aes_pkg::ST_DONE;
						else if (decrypt)
							round_cnt <= round_cnt - 1'b1;
						else
							round_cnt <= round_cnt + 1'b1;
					end
				end
				default:
					fsm <= aes_pkg::ST_IDLE;
			endcase
		end
	end

	// ---------------------------------------------------------
	// state and result registers
	// ---------------------------------------------------------
	always_ff @(posedge clk)
	begin
		// initial AddRoundKey on acceptance
		if (accept)
			state_q <= i_data ^ i_round_key;
		else if (step)
			state_q <= round_out;
		// result holds until the next block finishes
		if (step && last_round)
			o_data <= round_out;
	end

endmodule

// File: src/aes_gf_inverse.sv
// Multiplicative inverse in GF(2^8) through the composite field GF((2^4)^2).
// Pure combinational; zero maps to zero. Shared by the S-box paths.

`timescale 1ns/1ps

module aes_gf_inverse (
	input  aes_pkg::byte_t i_byte,
	output aes_pkg::byte_t o_inv
);

	// constant term of the extension polynomial y^2 + y + lambda
	localparam logic [3:0] LAMBDA = 4'he;

	// -------------------------------------------------------
	// GF(2^4) arithmetic, field polynomial x^4 + x + 1
	// -------------------------------------------------------
	function automatic logic [3:0] gf4_mul(input logic [3:0] a, input logic [3:0] b);
		logic [3:0] acc;
		logic [3:0] sh;
		acc = 4'h0;
		sh  = a;
		for (int i = 0; i < 4; i++)
		begin
			if (b[i])
				acc = acc ^ sh;
			// x^4 folds back to x + 1
			sh = {sh[2:0], 1'b0} ^ (sh[3] ? 4'h3 : 4'h0);
		end
		return acc;
	endfunction

	// squaring is linear in GF(2^4)
	function automatic logic [3:0] gf4_sq(input logic [3:0] a);
		return {a[3], a[1] ^ a[3], a[2], a[0] ^ a[2]};
	endfunction

	// a^14, gives 0 for 0
	function automatic logic [3:0] gf4_inv(input logic [3:0] a);
		logic [3:0] a2;
		logic [3:0] a4;
		logic [3:0] a8;
		a2 = gf4_sq(a);
		a4 = gf4_sq(a2);
		a8 = gf4_sq(a4);
		return gf4_mul(gf4_mul(a2, a4), a8);
	endfunction

	// -------------------------------------------------------
	// isomorphism between GF(2^8) and GF((2^4)^2)
	// -------------------------------------------------------
	// result is {high nibble, low nibble}
	function automatic logic [7:0] to_composite(input aes_pkg::byte_t a);
		logic t_a;
		logic t_b;
		logic t_c;
		logic [3:0] hi;
		logic [3:0] lo;
		t_a   = a[1] ^ a[7];
		t_b   = a[5] ^ a[7];
		t_c   = a[4] ^ a[6];
		lo[0] = t_c ^ a[0] ^ a[5];
		lo[1] = a[1] ^ a[2];
		lo[2] = t_a;
		lo[3] = a[2] ^ a[4];
		hi[0] = t_c ^ a[5];
		hi[1] = t_a ^ t_c;
		hi[2] = t_b ^ a[2] ^ a[3];
		hi[3] = t_b;
		return {hi, lo};
	endfunction

	function automatic aes_pkg::byte_t from_composite(input logic [3:0] hi, input logic [3:0] lo);
		logic t_a;
		logic t_b;
		aes_pkg::byte_t r;
		t_a  = lo[1] ^ hi[3];
		t_b  = hi[0] ^ hi[1];
		r[0] = lo[0] ^ hi[0];
		r[1] = t_b ^ hi[3];
		r[2] = t_a ^ t_b;
		r[3] = t_b ^ lo[1] ^ hi[2];
		r[4] = t_a ^ t_b ^ lo[3];
		r[5] = t_b ^ lo[2];
		r[6] = t_a ^ lo[2] ^ lo[3] ^ hi[0];
		r[7] = t_b ^ lo[2] ^ hi[3];
		return r;
	endfunction

	logic [3:0] a_hi;
	logic [3:0] a_lo;
	logic [3:0] d_inv;

	// (hi*y + lo)^-1 = hi*d*y + (hi + lo)*d
	// with d = (hi^2 * lambda + hi*lo + lo^2)^-1
	always_comb
	begin
		{a_hi, a_lo} = to_composite(i_byte);
		d_inv = gf4_inv(gf4_mul(gf4_sq(a_hi), LAMBDA) ^ gf4_mul(a_hi, a_lo) ^ gf4_sq(a_lo));
		o_inv = from_composite(gf4_mul(a_hi, d_inv), gf4_mul(a_hi ^ a_lo, d_inv));
	end

endmodule

// File: src/aes_key_expand.sv
// AES-128 key schedule. i_start loads the cipher key; round keys 1 to 10 follow,
// one per clock, and all eleven stay readable by index. o_key_ready marks a full set.

`timescale 1ns/1ps

module aes_key_expand (
	input  logic             clk,
	input  logic             reset,
	input  logic             i_start,
	input  aes_pkg::key_t    i_key,
	input  aes_pkg::round_t  i_round_idx,
	output aes_pkg::key_t    o_round_key,
	output logic             o_key_ready
);

	// round key storage, index 0 holds the cipher key
	aes_pkg::key_t   round_keys [0:aes_pkg::NUM_ROUNDS];
	// most recent key written, source of the next one
	aes_pkg::key_t   prev_key;
	aes_pkg::key_t   base_key;
	aes_pkg::key_t   next_key;
	aes_pkg::byte_t  rcon;
	aes_pkg::byte_t  rcon_cur;
	aes_pkg::round_t key_idx;
	logic            busy;
	aes_pkg::word_t  rot_word;
	aes_pkg::word_t  inv_word;
	aes_pkg::word_t  sub_word;

	// ---------------------------------------------------------
	// next round key
	// ---------------------------------------------------------
	// start cycle works straight from i_key so key 1 is ready at once
	assign base_key = i_start ? i_key : prev_key;
	assign rcon_cur = i_start ? 8'h01 : rcon;

	// RotWord of the last word
	assign rot_word = {base_key[23:0], base_key[31:24]};

	// SubWord field inverses
	for (genvar g = 0; g < 4; g++)
	begin : g_subword
		aes_gf_inverse u_inv (
			.i_byte (rot_word[8*g +: 8]),
			.o_inv  (inv_word[8*g +: 8])
		);
	end

	always_comb
	begin
		for (int i = 0; i < 4; i++)
			sub_word[8*i +: 8] = aes_pkg::fwd_affine(inv_word[8*i +: 8]);
		// word chain, w0 first
		next_key[127:96] = base_key[127:96] ^ sub_word ^ {rcon_cur, 24'h000000};
		next_key[95:64]  = base_key[95:64] ^ next_key[127:96];
		next_key[63:32]  = base_key[63:32] ^ next_key[95:64];
		next_key[31:0]   = base_key[31:0] ^ next_key[63:32];
	end

	// ---------------------------------------------------------
	// schedule control
	// ---------------------------------------------------------
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			busy        <= 1'b0;
			key_idx     <= '0;
			rcon        <= '0;
			o_key_ready <= 1'b0;
		end
		else if (i_start)
		begin
			// keys 0 and 1 land on this edge
			busy        <= 1'b1;
			key_idx     <= 4'd2;
			rcon        <= aes_pkg::xtime(8'h01);
			o_key_ready <= 1'b0;
		end
		else if (busy)
		begin
			rcon    <= aes_pkg::xtime(rcon);
			key_idx <= key_idx + 1'b1;
			if (key_idx == aes_pkg::round_t'(aes_pkg::NUM_ROUNDS))
			begin
				busy        <= 1'b0;
				o_key_ready <= 1'b1;
			end
		end
	end

	// key storage
	always_ff @(posedge clk)
	begin
		if (i_start)
		begin
			round_keys[0] <= i_key;
			round_keys[1] <= next_key;
			prev_key      <= next_key;
		end
		else if (busy)
		begin
			round_keys[key_idx] <= next_key;
			prev_key            <= next_key;
		end
	end

	// read port for the core
	assign o_round_key = round_keys[i_round_idx];

endmodule

// File: src/aes_pkg.sv
// Shared types, constants and byte helpers for the AES-128 engine.
// Every RTL file refers to these by scoped name, aes_pkg::name.

package aes_pkg;

	// -------------------------------------------------------
	// widths with a meaning
	// -------------------------------------------------------
	typedef logic [31:0]  word_t;
	typedef logic [7:0]   byte_t;
	typedef logic [127:0] block_t;
	typedef logic [127:0] key_t;
	typedef logic [3:0]   round_t;
	typedef logic [3:0]   data_sel_t;
	typedef logic [1:0]   read_sel_t;

	// AES-128 only
	localparam int NUM_ROUNDS = 10;

	// bus write select codes
	localparam data_sel_t SEL_KEY_LAST   = 4'h3;
	localparam data_sel_t SEL_DATA_FIRST = 4'h8;
	localparam data_sel_t SEL_DATA_LAST  = 4'hb;

	// core control states
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ROUND,
		ST_DONE
	} core_state_t;

	// -------------------------------------------------------
	// GF(2^8) helpers, AES polynomial x^8 + x^4 + x^3 + x + 1
	// -------------------------------------------------------
	// multiply by x
	function automatic byte_t xtime(input byte_t b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	// S-box affine step applied after the field inverse
	function automatic byte_t fwd_affine(input byte_t b);
		byte_t r;
		for (int i = 0; i < 8; i++)
			r[i] = b[i] ^ b[(i + 4) % 8] ^ b[(i + 5) % 8] ^ b[(i + 6) % 8] ^ b[(i + 7) % 8];
		return r ^ 8'h63;
	endfunction

	// undoes fwd_affine, used ahead of the inverse for InvSubBytes
	function automatic byte_t inv_affine(input byte_t b);
		byte_t r;
		for (int i = 0; i < 8; i++)
			r[i] = b[(i + 2) % 8] ^ b[(i + 5) % 8] ^ b[(i + 7) % 8];
		return r ^ 8'h05;
	endfunction

endpackage

// File: src/aes_round.sv
// One AES round on a 128-bit state, encryption or inverse cipher order.
// i_last drops (Inv)MixColumns for the final round. Fully combinational.

`timescale 1ns/1ps

module aes_round (
	input  aes_pkg::block_t i_state,
	input  aes_pkg::key_t   i_round_key,
	input  logic            i_decrypt,
	input  logic            i_last,
	output aes_pkg::block_t o_state
);

	// byte k of the state sits at bits 127-8k down, column-major

	// MixColumns of one column, row 0 in the top byte
	function automatic aes_pkg::word_t mix_col(input aes_pkg::word_t col);
		aes_pkg::byte_t a [4];
		aes_pkg::byte_t t;
		aes_pkg::word_t r;
		for (int i = 0; i < 4; i++)
			a[i] = col[31-8*i -: 8];
		t = a[0] ^ a[1] ^ a[2] ^ a[3];
		// b_i = a_i + t + 2(a_i + a_i+1)
		for (int i = 0; i < 4; i++)
			r[31-8*i -: 8] = a[i] ^ t ^ aes_pkg::xtime(a[i] ^ a[(i + 1) % 4]);
		return r;
	endfunction

	// InvMixColumns as a {05,00,04,00} premultiply then MixColumns
	function automatic aes_pkg::word_t inv_mix_col(input aes_pkg::word_t col);
		aes_pkg::byte_t a [4];
		aes_pkg::byte_t u;
		aes_pkg::byte_t v;
		for (int i = 0; i < 4; i++)
			a[i] = col[31-8*i -: 8];
		u = aes_pkg::xtime(aes_pkg::xtime(a[0] ^ a[2]));
		v = aes_pkg::xtime(aes_pkg::xtime(a[1] ^ a[3]));
		return mix_col({a[0] ^ u, a[1] ^ v, a[2] ^ u, a[3] ^ v});
	endfunction

	aes_pkg::block_t inv_in;
	aes_pkg::block_t inv_out;
	aes_pkg::block_t sub;
	aes_pkg::block_t shifted;
	aes_pkg::block_t pre_mix;
	aes_pkg::block_t mixed;

	// ---------------------------------------------------------
	// (Inv)SubBytes
	// ---------------------------------------------------------
	// one inverter per byte serves both directions
	always_comb
	begin
		for (int k = 0; k < 16; k++)
		begin
			if (i_decrypt)
				inv_in[127-8*k -: 8] = aes_pkg::inv_affine(i_state[127-8*k -: 8]);
			else
				inv_in[127-8*k -: 8] = i_state[127-8*k -: 8];
		end
	end

	for (genvar g = 0; g < 16; g++)
	begin : g_sbox
		aes_gf_inverse u_inv (
			.i_byte (inv_in[127-8*g -: 8]),
			.o_inv  (inv_out[127-8*g -: 8])
		);
	end

	always_comb
	begin
		for (int k = 0; k < 16; k++)
		begin
			if (i_decrypt)
				sub[127-8*k -: 8] = inv_out[127-8*k -: 8];
			else
				sub[127-8*k -: 8] = aes_pkg::fwd_affine(inv_out[127-8*k -: 8]);
		end
	end

	// ---------------------------------------------------------
	// (Inv)ShiftRows
	// ---------------------------------------------------------
	// bytewise substitution commutes with the row shift,
	// so decryption may substitute first
	always_comb
	begin
		int src_c;
		for (int c = 0; c < 4; c++)
		begin
			for (int r = 0; r < 4; r++)
			begin
				// row r rotates left by r, or right for decryption
				if (i_decrypt)
					src_c = (c + 4 - r) % 4;
				else
					src_c = (c + r) % 4;
				shifted[127-8*(r+4*c) -: 8] = sub[127-8*(r+4*src_c) -: 8];
			end
		end
	end

	// ---------------------------------------------------------
	// mixing and round key
	// ---------------------------------------------------------
	always_comb
	begin
		// inverse cipher adds the key before InvMixColumns
		if (i_decrypt)
			pre_mix = shifted ^ i_round_key;
		else
			pre_mix = shifted;
		for (int c = 0; c < 4; c++)
		begin
			if (i_last)
				mixed[127-32*c -: 32] = pre_mix[127-32*c -: 32];
			else if (i_decrypt)
				mixed[127-32*c -: 32] = inv_mix_col(pre_mix[127-32*c -: 32]);
			else
				mixed[127-32*c -: 32] = mix_col(pre_mix[127-32*c -: 32]);
		end
		o_state = i_decrypt ? mixed : (mixed ^ i_round_key);
	end

endmodule
